// File: dv/rx_align_golden.txt
# name fly rden_dly count_x wd_sel(hex) bit_sel(hex) ch0_stb ch0_stb2 ch1_stb ch1_stb2
#   result(0 none, 1 done, 2 err) coding_err pos_err; strobe cycle 0 means no strobe
deskew_a      0 2 0 01 0000000004  3  0 10 0 1 0 0
deskew_b      0 0 0 01 0000000004 12  0  5 0 1 0 0
deskew_c      0 5 2 02 0000100000  4  0  4 0 1 0 0
overflow_err  0 1 0 01 0000000004  2  0 25 0 2 0 0
align_fly     1 1 0 01 0000000004  2 24 25 0 1 0 0
blanking      0 0 4 02 0000100000  1  6  8 0 1 0 0
code_wd_zero  0 0 0 00 0000000020  0  0  0 0 0 1 0
code_multi    0 0 0 03 0000000002  0  0  0 0 0 1 0
code_bit_zero 0 0 0 01 0000000000  0  0  0 0 0 1 0
pos_over      0 0 0 04 0000000002  0  0  0 0 0 0 1
pos_edge      0 0 0 02 8000000000  0  0  0 0 0 0 0
pos_ok        0 0 0 01 0000000020  0  0  0 0 0 0 0

// File: dv/rx_align_tb.sv
/* Testbench for the RX channel alignment block.
   Runs the scenarios of the golden file, one after reset each. */

module rx_align_tb;

  localparam int num_channels     = 2;
  localparam int bits_per_channel = 80;
  localparam int cyc_limit        = 200;  // Per scenario wait
  localparam int data_checks      = 8;

  logic                                     com_clk;
  logic                                     rst_com_n;
  logic                                     rx_online;
  logic                                     align_fly;
  ca_align_pkg::rden_dly_t                  rden_dly;
  ca_align_pkg::count_x_t                   count_x;
  ca_align_pkg::stb_wd_sel_t                rx_stb_wd_sel;
  ca_align_pkg::stb_bit_sel_t               rx_stb_bit_sel;
  logic [num_channels*bits_per_channel-1:0] rx_din;
  logic [num_channels*bits_per_channel-1:0] rx_dout;
  logic                                     align_done;
  logic                                     align_err;
  logic                                     rx_stb_pos_err;
  logic                                     rx_stb_pos_coding_err;
  logic [num_channels-1:0]                  fifo_full;
  logic [num_channels-1:0]                  fifo_empty;

  logic [bits_per_channel-1:0] gen [num_channels][256];  // Words sent, by cycle
  int                          stb_a [num_channels];
  int                          stb_b [num_channels];
  int                          stb_pos;

  rx_align_top dut_i (
    .com_clk               (com_clk),
    .rst_com_n             (rst_com_n),
    .rx_online             (rx_online),
    .align_fly             (align_fly),
    .rden_dly              (rden_dly),
    .count_x               (count_x),
    .rx_stb_wd_sel         (rx_stb_wd_sel),
    .rx_stb_bit_sel        (rx_stb_bit_sel),
    .rx_din                (rx_din),
    .rx_dout               (rx_dout),
    .align_done            (align_done),
    .align_err             (align_err),
    .rx_stb_pos_err        (rx_stb_pos_err),
    .rx_stb_pos_coding_err (rx_stb_pos_coding_err),
    .fifo_full             (fifo_full),
    .fifo_empty            (fifo_empty)
  );

  initial
  begin
    com_clk = 1'b0;
    forever #50 com_clk = ~com_clk;
  end

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////

  task automatic stop_run(string msg);
    $display("%s", msg);
    $display("Result: FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_data(string name, logic [bits_per_channel-1:0] exp,
                            logic [bits_per_channel-1:0] act);
    if (act !== exp)
      stop_run($sformatf("error %s: expected %h, actual %h", name, exp, act));
  endtask

  // Pairs such as {align_done, align_err} or fifo_empty
  task automatic check_status(string name, logic [1:0] exp, logic [1:0] act);
    if (act !== exp)
      stop_run($sformatf("error %s: expected %b, actual %b", name, exp, act));
  endtask

  // {coding error, position error}
  task automatic check_flags(string name, logic [1:0] exp, logic [1:0] act);
    if (act !== exp)
      stop_run($sformatf("error %s: expected %b, actual %b", name, exp, act));
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  // Highest set bit of a select
  function automatic int high_index(logic [63:0] v);
    int idx;
    idx = 0;
    for (int i = 0; i < 64; i++)
    begin
      if (v[i])
        idx = i;
    end
    return idx;
  endfunction

  // Random word with the cycle in 15:8 and the strobe only where scheduled
  function automatic logic [num_channels*bits_per_channel-1:0] build_din(int k);
    logic [bits_per_channel-1:0]              w;
    logic [num_channels*bits_per_channel-1:0] bus;
    bus = '0;
    for (int c = 0; c < num_channels; c++)
    begin
      w[31:0]  = $urandom();
      w[63:32] = $urandom();
      w[79:64] = 16'($urandom());
      w[15:8]  = 8'(k);
      w[stb_pos] = 1'b0;
      if (k != 0 && (k == stb_a[c] || k == stb_b[c]))
        w[stb_pos] = 1'b1;
      gen[c][k] = w;
      bus[c*bits_per_channel +: bits_per_channel] = w;
    end
    return bus;
  endfunction

  task automatic run_scenario(string name, int fly, int dly, int cx, logic [7:0] wd,
                              logic [39:0] bs, int res, int coding, int pos);
    int         eff [num_channels];
    int         cyc;
    int         pop_start;
    int         p;
    int         checked;
    bit         seen;
    logic [1:0] late;
    @(posedge com_clk);
    rst_com_n      <= 1'b0;
    rx_online      <= 1'b0;
    rx_din         <= '0;
    align_fly      <= fly[0];
    rden_dly       <= 3'(dly);
    count_x        <= 8'(cx);
    rx_stb_wd_sel  <= wd;
    rx_stb_bit_sel <= bs;
    repeat (5) @(posedge com_clk);
    rst_com_n <= 1'b1;
    @(negedge com_clk);
    check_status({name, " reset status"}, 2'b00, {align_done, align_err});
    check_status({name, " reset empty"}, 2'b11, fifo_empty);
    check_flags({name, " select flags"}, {coding[0], pos[0]},
                {rx_stb_pos_coding_err, rx_stb_pos_err});
    if (res == 0)
      return;

    // Alignment locks to each channel's last strobe
    pop_start = 0;
    for (int c = 0; c < num_channels; c++)
    begin
      eff[c] = (stb_b[c] != 0) ? stb_b[c] : stb_a[c];
      if (eff[c] > pop_start)
        pop_start = eff[c];
    end
    pop_start = pop_start + 2 + dly;
    stb_pos = high_index({56'b0, wd}) * ca_align_pkg::stb_word_bits + high_index({24'b0, bs});

    // Channel whose strobe comes last, never written once the error is taken
    late = (stb_a[1] > stb_a[0]) ? 2'b10 : 2'b01;

    cyc = 0;
    seen = 1'b0;
    checked = 0;
    @(posedge com_clk);
    rx_online <= 1'b1;
    rx_din    <= build_din(0);
    for (int n = 0; n < cyc_limit && checked < data_checks; n++)
    begin
      @(negedge com_clk);
      seen = seen | ((res == 1) ? align_done : align_err);
      check_status({name, " status"}, (res == 1) ? {seen, 1'b0} : {1'b0, seen},
                   {align_done, align_err});
      if (seen)
      begin
        if (res == 1)
        begin
          p = cyc - pop_start;
          if (p < 0)
            stop_run($sformatf("%s: align_done rose before the first pop was due", name));
          for (int c = 0; c < num_channels; c++)
            check_data($sformatf("%s ch%0d pop %0d", name, c, p), gen[c][eff[c] + 1 + p],
                       rx_dout[c*bits_per_channel +: bits_per_channel]);
          check_status({name, " full flags"}, 2'b00, fifo_full);
          check_status({name, " empty flags"}, 2'b00, fifo_empty);
        end
        else
        begin
          check_status({name, " full flags"}, ~late, fifo_full);  // Early channel overflowed
          check_status({name, " empty flags"}, late, fifo_empty);
        end
        checked++;
      end
      @(posedge com_clk);
      cyc++;
      rx_din <= build_din(cyc);
    end
    if (checked < data_checks)
      stop_run($sformatf("%s: timed out waiting for the alignment result", name));
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial
  begin
    int          fd;
    int          r;
    string       line;
    string       name;
    int          fly;
    int          dly;
    int          cx;
    int          res;
    int          coding;
    int          pos;
    logic [7:0]  wd;
    logic [39:0] bs;
    rst_com_n      = 1'b0;
    rx_online      = 1'b0;
    align_fly      = 1'b0;
    rden_dly       = '0;
    count_x        = '0;
    rx_stb_wd_sel  = 8'h01;
    rx_stb_bit_sel = 40'h1;
    rx_din         = '0;
    stb_pos        = 0;
    void'($urandom(21));
    fd = $fopen("dv/rx_align_golden.txt", "r");
    if (fd == 0)
      stop_run("could not open the golden file dv/rx_align_golden.txt");
    while (!$feof(fd))
    begin
      r = $fgets(line, fd);
      if (r == 0 || line.len() < 2 || line[0] == "#")
        continue;
      r = $sscanf(line, "%s %d %d %d %h %h %d %d %d %d %d %d %d", name, fly, dly, cx,
                  wd, bs, stb_a[0], stb_b[0], stb_a[1], stb_b[1], res, coding, pos);
      if (r != 13)
        stop_run($sformatf("malformed golden line: %s", line));
      run_scenario(name, fly, dly, cx, wd, bs, res, coding, pos);
      $display("scenario %s done", name);
    end
    $fclose(fd);
    $display("Result: PASSED");
    $finish;
  end

endmodule

// File: run.sh
#!/usr/bin/env bash
# Build and run the alignment testbench with Verilator from the project root.
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f src.f --top-module rx_align_tb \
  --Mdir obj_dir -o rx_align_sim
status=$?
if [ $status -ne 0 ]; then
  echo "build failed with status $status"
  exit $status
fi

./obj_dir/rx_align_sim
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed with status $status"
  exit $status
fi
exit 0

// File: src.f
src/ca_align_pkg.sv
src/rx_stb_detect.sv
src/rx_align_fifo.sv
src/rx_align_ctrl.sv
src/rx_stb_pos_check.sv
src/rx_align_top.sv
dv/rx_align_tb.sv

// File: src/ca_align_pkg.sv
/* Shared constants and types for the RX channel alignment block.
   Referenced by scoped name from the RTL and the testbench. */

package ca_align_pkg;

  ////////////////////////////////////////////////////////////
  // Strobe position geometry
  ////////////////////////////////////////////////////////////

  localparam int stb_word_bits = 40;  // Width of one selectable word
  localparam int stb_words     = 8;   // Covers up to 320 bits per channel

  typedef logic [stb_words-1:0]     stb_wd_sel_t;   // One-hot word select
  typedef logic [stb_word_bits-1:0] stb_bit_sel_t;  // One-hot bit select

  // Static configuration
  typedef logic [7:0] count_x_t;   // Blanking cycles after online
  typedef logic [2:0] rden_dly_t;  // Extra cycles before the common pop

  ////////////////////////////////////////////////////////////
  // Alignment FSM
  ////////////////////////////////////////////////////////////

  typedef enum logic [2:0] {
    idle       = 3'd0,
    online     = 3'd1,
    aligned    = 3'd2,
    err        = 3'd3,
    done       = 3'd4,
    soft_reset = 3'd5
  } rx_state_t;

endpackage

// File: src/rx_align_ctrl.sv
/* Alignment FSM with the read-enable delay and the common FIFO pop.
   Reports done or error, and runs the soft reset for align on the fly. */

module rx_align_ctrl #(
  parameter int num_channels = 2
) (
  input  logic                    com_clk,
  input  logic                    rst_com_n,
  input  logic                    rx_online,
  input  logic                    align_fly,
  input  ca_align_pkg::rden_dly_t rden_dly,
  input  logic [num_channels-1:0] first_stb_det,
  input  logic [num_channels-1:0] overflow_pulse,
  output logic                    fifo_pop,
  output logic                    soft_reset,
  output logic                    stb_enable,
  output logic                    align_done,
  output logic                    align_err
);

  ca_align_pkg::rx_state_t state;
  ca_align_pkg::rx_state_t state_nxt;
  ca_align_pkg::rden_dly_t rd_dly;
  logic                    rx_online_del;
  logic                    all_stb_seen;

  assign all_stb_seen = &first_stb_det;
  assign fifo_pop     = all_stb_seen & ~(|rd_dly);  // Same pop for every FIFO

  assign soft_reset = (state == ca_align_pkg::soft_reset);
  assign stb_enable = (state == ca_align_pkg::online) |
                      (state == ca_align_pkg::aligned) |
                      (state == ca_align_pkg::done);

  ////////////////////////////////////////////////////////////
  // Read delay and status registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge com_clk or negedge rst_com_n)
  begin
    if (!rst_com_n)
    begin
      rx_online_del <= 1'b0;
      rd_dly        <= '0;
      align_done    <= 1'b0;
      align_err     <= 1'b0;
    end
    else
    begin
      rx_online_del <= rx_online;
      if (rx_online && !rx_online_del)
        rd_dly <= rden_dly;
      else if (all_stb_seen && (|rd_dly))
        rd_dly <= rd_dly - 1'b1;  // Runs only once every channel is writing
      align_done <= (state == ca_align_pkg::done);
      align_err  <= (state == ca_align_pkg::err);
    end
  end

  always_ff @(posedge com_clk or negedge rst_com_n)
  begin
    if (!rst_com_n)
      state <= ca_align_pkg::idle;
    else
      state <= state_nxt;
  end

  // Next state
  always_comb
  begin
    state_nxt = state;
    case (state)
      ca_align_pkg::idle:
      begin
        if (rx_online)
          state_nxt = ca_align_pkg::online;
      end
      ca_align_pkg::online:
      begin
        if (|overflow_pulse)  // Skew beyond the FIFO depth
          state_nxt = align_fly ? ca_align_pkg::soft_reset : ca_align_pkg::err;
        else if (all_stb_seen)
          state_nxt = ca_align_pkg::aligned;
      end
      ca_align_pkg::aligned:
      begin
        if (rd_dly == '0)
          state_nxt = ca_align_pkg::done;
      end
      ca_align_pkg::err:
      begin
        if (align_fly)
          state_nxt = ca_align_pkg::soft_reset;
      end
      ca_align_pkg::done:       state_nxt = ca_align_pkg::done;
      ca_align_pkg::soft_reset: state_nxt = ca_align_pkg::online;  // Single cycle
      default:                  state_nxt = ca_align_pkg::idle;
    endcase
  end

endmodule

// File: src/rx_align_fifo.sv
/* Synchronous alignment FIFO for one channel.
   Written from the first strobe onward, popped in step with all channels. */

module rx_align_fifo #(
  parameter int bits_per_channel = 80,
  parameter int ad_width         = 4
) (
  input  logic                        com_clk,
  input  logic                        rst_com_n,
  input  logic                        soft_reset,
  input  logic                        push,
  input  logic                        pop,
  input  logic [bits_per_channel-1:0] din,
  output logic [bits_per_channel-1:0] dout,
  output logic                        fifo_full,
  output logic                        fifo_empty,
  output logic                        overflow_pulse
);

  localparam int depth = 2 ** ad_width;

  logic [bits_per_channel-1:0] mem [depth];
  logic [ad_width:0]           wr_ptr;
  logic [ad_width:0]           rd_ptr;
  logic [ad_width:0]           level;
  logic                        wr_en;
  logic                        rd_en;

  ////////////////////////////////////////////////////////////
  // Flags from the pointer difference
  ////////////////////////////////////////////////////////////

  // Extra pointer bit separates full from empty
  assign level      = wr_ptr - rd_ptr;
  assign fifo_full  = level[ad_width];
  assign fifo_empty = (level == '0);

  assign wr_en = push & ~fifo_full;   // Push into a full FIFO is lost
  assign rd_en = pop & ~fifo_empty;

  // Head of the FIFO, read without a register stage
  assign dout = mem[rd_ptr[ad_width-1:0]];

  // Storage
  always_ff @(posedge com_clk)
  begin
    if (wr_en)
      mem[wr_ptr[ad_width-1:0]] <= din;
  end

  always_ff @(posedge com_clk or negedge rst_com_n)
  begin
    if (!rst_com_n)
    begin
      wr_ptr         <= '0;
      rd_ptr         <= '0;
      overflow_pulse <= 1'b0;
    end
    else if (soft_reset)
    begin
      wr_ptr         <= '0;
      rd_ptr         <= '0;
      overflow_pulse <= 1'b0;
    end
    else
    begin
      if (wr_en)
        wr_ptr <= wr_ptr + 1'b1;
      if (rd_en)
        rd_ptr <= rd_ptr + 1'b1;
      overflow_pulse <= push & fifo_full;  // One cycle per dropped word
    end
  end

endmodule

// File: src/rx_align_top.sv
/* Top level of the RX channel alignment block.
   Splits the input bus per channel and wires detection, FIFOs and control. */

module rx_align_top #(
  parameter int num_channels     = 2,
  parameter int bits_per_channel = 80,   // Up to 320
  parameter int ad_width         = 4     // FIFO depth 2**ad_width
) (
  input  logic                                     com_clk,
  input  logic                                     rst_com_n,
  input  logic                                     rx_online,
  input  logic                                     align_fly,
  input  ca_align_pkg::rden_dly_t                  rden_dly,
  input  ca_align_pkg::count_x_t                   count_x,
  input  ca_align_pkg::stb_wd_sel_t                rx_stb_wd_sel,
  input  ca_align_pkg::stb_bit_sel_t               rx_stb_bit_sel,
  input  logic [num_channels*bits_per_channel-1:0] rx_din,
  output logic [num_channels*bits_per_channel-1:0] rx_dout,
  output logic                                     align_done,
  output logic                                     align_err,
  output logic                                     rx_stb_pos_err,
  output logic                                     rx_stb_pos_coding_err,
  output logic [num_channels-1:0]                  fifo_full,
  output logic [num_channels-1:0]                  fifo_empty
);

  logic [num_channels-1:0] fifo_push;
  logic [num_channels-1:0] first_stb_det;
  logic [num_channels-1:0] overflow_pulse;
  logic                    fifo_pop;
  logic                    soft_reset;
  logic                    stb_enable;

  rx_stb_detect #(
    .num_channels     (num_channels),
    .bits_per_channel (bits_per_channel)
  ) stb_detect_i (
    .com_clk        (com_clk),
    .rst_com_n      (rst_com_n),
    .rx_online      (rx_online),
    .stb_enable     (stb_enable),
    .soft_reset     (soft_reset),
    .count_x        (count_x),
    .rx_stb_wd_sel  (rx_stb_wd_sel),
    .rx_stb_bit_sel (rx_stb_bit_sel),
    .rx_din         (rx_din),
    .fifo_push      (fifo_push),
    .first_stb_det  (first_stb_det)
  );

  ////////////////////////////////////////////////////////////
  // One alignment FIFO per channel
  ////////////////////////////////////////////////////////////

  for (genvar c = 0; c < num_channels; c++)
  begin : g_fifo
    rx_align_fifo #(
      .bits_per_channel (bits_per_channel),
      .ad_width         (ad_width)
    ) align_fifo_i (
      .com_clk        (com_clk),
      .rst_com_n      (rst_com_n),
      .soft_reset     (soft_reset),
      .push           (fifo_push[c]),
      .pop            (fifo_pop),
      .din            (rx_din[c*bits_per_channel +: bits_per_channel]),
      .dout           (rx_dout[c*bits_per_channel +: bits_per_channel]),
      .fifo_full      (fifo_full[c]),
      .fifo_empty     (fifo_empty[c]),
      .overflow_pulse (overflow_pulse[c])
    );
  end

  rx_align_ctrl #(
    .num_channels (num_channels)
  ) align_ctrl_i (
    .com_clk        (com_clk),
    .rst_com_n      (rst_com_n),
    .rx_online      (rx_online),
    .align_fly      (align_fly),
    .rden_dly       (rden_dly),
    .first_stb_det  (first_stb_det),
    .overflow_pulse (overflow_pulse),
    .fifo_pop       (fifo_pop),
    .soft_reset     (soft_reset),
    .stb_enable     (stb_enable),
    .align_done     (align_done),
    .align_err      (align_err)
  );

  // Select checks, no clock
  rx_stb_pos_check #(
    .bits_per_channel (bits_per_channel)
  ) stb_pos_check_i (
    .rx_stb_wd_sel         (rx_stb_wd_sel),
    .rx_stb_bit_sel        (rx_stb_bit_sel),
    .rx_stb_pos_coding_err (rx_stb_pos_coding_err),
    .rx_stb_pos_err        (rx_stb_pos_err)
  );

endmodule

// File: src/rx_stb_detect.sv
/* Per-channel strobe detection with a shared blanking timer.
   Produces the sticky FIFO write enables and first-strobe flags. */

module rx_stb_detect #(
  parameter int num_channels     = 2,
  parameter int bits_per_channel = 80
) (
  input  logic                                   com_clk,
  input  logic                                   rst_com_n,
  input  logic                                   rx_online,
  input  logic                                   stb_enable,
  input  logic                                   soft_reset,
  input  ca_align_pkg::count_x_t                 count_x,
  input  ca_align_pkg::stb_wd_sel_t              rx_stb_wd_sel,
  input  ca_align_pkg::stb_bit_sel_t             rx_stb_bit_sel,
  input  logic [num_channels*bits_per_channel-1:0] rx_din,
  output logic [num_channels-1:0]                fifo_push,
  output logic [num_channels-1:0]                first_stb_det
);

  localparam int wbits    = ca_align_pkg::stb_word_bits;
  localparam int pad_bits = ca_align_pkg::stb_words * wbits;

  logic [pad_bits-1:0]     din_pad [num_channels];
  logic [wbits-1:0]        word    [num_channels];
  logic [num_channels-1:0] d_stb_det;
  logic [num_channels-1:0] stb_det;
  ca_align_pkg::count_x_t  timer_x;
  logic                    rx_online_del;

  // Word select, lowest set select bit wins
  always_comb
  begin
    for (int c = 0; c < num_channels; c++)
    begin
      din_pad[c] = '0;  // Words past the channel width read as zero
      din_pad[c][bits_per_channel-1:0] = rx_din[c*bits_per_channel +: bits_per_channel];
      word[c] = din_pad[c][wbits-1:0];
      for (int w = ca_align_pkg::stb_words - 1; w >= 0; w--)
      begin
        if (rx_stb_wd_sel[w])
          word[c] = din_pad[c][w*wbits +: wbits];
      end
      d_stb_det[c] = stb_enable & (|(word[c] & rx_stb_bit_sel));
    end
  end

  ////////////////////////////////////////////////////////////
  // Blanking timer and sticky flags
  ////////////////////////////////////////////////////////////

  always_ff @(posedge com_clk or negedge rst_com_n)
  begin
    if (!rst_com_n)
    begin
      rx_online_del <= 1'b0;
      timer_x       <= '0;
      stb_det       <= '0;
      first_stb_det <= '0;
      fifo_push     <= '0;
    end
    else
    begin
      rx_online_del <= rx_online;
      if (rx_online && !rx_online_del)
        timer_x <= count_x;  // Window starts with online
      else if (|timer_x)
        timer_x <= timer_x - 1'b1;

      if (soft_reset)
      begin
        stb_det       <= '0;
        first_stb_det <= '0;
        fifo_push     <= '0;
      end
      else if (rx_online && (timer_x == '0))
      begin
        stb_det       <= d_stb_det;
        first_stb_det <= first_stb_det | stb_det;  // One cycle behind stb_det
        fifo_push     <= fifo_push | d_stb_det;    // First write is the word after
      end
    end
  end

endmodule

// File: src/rx_stb_pos_check.sv
/* Static checks on the strobe word and bit selects.
   Flags a select that is not one-hot, or a position past the channel. */

module rx_stb_pos_check #(
  parameter int bits_per_channel = 80
) (
  input  ca_align_pkg::stb_wd_sel_t  rx_stb_wd_sel,
  input  ca_align_pkg::stb_bit_sel_t rx_stb_bit_sel,
  output logic                       rx_stb_pos_coding_err,
  output logic                       rx_stb_pos_err
);

  logic [3:0] wd_ones;
  logic [5:0] bit_ones;
  logic [2:0] wd_idx;   // Highest set word select bit
  logic [5:0] bit_idx;  // Highest set bit select bit
  logic [8:0] stb_loc;

  always_comb
  begin
    wd_ones = '0;
    wd_idx  = '0;
    for (int w = 0; w < ca_align_pkg::stb_words; w++)
    begin
      wd_ones = wd_ones + {3'b0, rx_stb_wd_sel[w]};
      if (rx_stb_wd_sel[w])
        wd_idx = 3'(w);
    end
    bit_ones = '0;
    bit_idx  = '0;
    for (int b = 0; b < ca_align_pkg::stb_word_bits; b++)
    begin
      bit_ones = bit_ones + {5'b0, rx_stb_bit_sel[b]};
      if (rx_stb_bit_sel[b])
        bit_idx = 6'(b);
    end
  end

  // Word start plus bit offset
  assign stb_loc = 9'(wd_idx) * 9'(ca_align_pkg::stb_word_bits) + 9'(bit_idx);

  assign rx_stb_pos_coding_err = (wd_ones != 4'd1) | (bit_ones != 6'd1);
  assign rx_stb_pos_err        = (int'(stb_loc) > bits_per_channel);

endmodule
